// File: Makefile
SRCS = $(wildcard verilog/*.sv) testbench/tb_rv_core.sv

obj_dir/Vtb_rv_core: $(SRCS) vlog.f
	verilator --binary --timing -f vlog.f --top-module tb_rv_core -Mdir obj_dir

.PHONY: run clean

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: testbench/rv_patterns.hex
// Program words from address 0, eight per line
// @100 holds the store count N, then N records of address, data, strobe
@000
10000093 12345137 67810113 0020A023 00001197 0030A223 FFB00213 00300293
40520333 405353B3 00535433 005294B3 00522533 005235B3 00414633 009566B3
00617733 0070A423 0080A623 00C0A823 00D0AA23 00E0AC23 00B0AE23 FFC22793
FFF2B813 FFF14893 0702E913 0FF17993 01C29A13 40125A93 01C25B13 01078BB3
014B8BB3 0310A023 0320A223 0330A423 0350A623 0360A823 0370AA23 00528463
0200AE23 00520463 001D0D13 00521463 100D0D13 00529463 001D0D13 00524463
0200AE23 0042C463 001D0D13 0042D463 100D0D13 00525463 001D0D13 0042E463
0200AE23 00526463 001D0D13 00527463 100D0D13 0042F463 001D0D13 00C00DEF
0200AE23 100D0D13 03B0AC23 00000E17 010E0EE7 0200AE23 100D0D13 07D0A823
07A0AA23 04208023 051080A3 04208123 051081A3 04209223 05109323 04108F03
05E0A823 0410CF83 05F0AA23 04609F03 05E0AC23 0440DF83 05F0AE23 0400AF03
07E0A023 0000006F
@100
0000001C
00000100 12345678 0000000F  00000104 00001010 0000000F  00000108 FFFFFFFF 0000000F
0000010C 1FFFFFFF 0000000F  00000110 EDCBA983 0000000F  00000114 00000019 0000000F
00000118 12345678 0000000F  0000011C 00000000 0000000F  00000120 EDCBA987 0000000F
00000124 00000073 0000000F  00000128 00000078 0000000F  0000012C FFFFFFFD 0000000F
00000130 0000000F 0000000F  00000134 30000002 0000000F  00000138 00000100 0000000F
00000170 00000114 0000000F  00000174 00000006 0000000F  00000140 78787878 00000001
00000141 87878787 00000002  00000142 78787878 00000004  00000143 87878787 00000008
00000144 56785678 00000003  00000146 A987A987 0000000C  00000150 FFFFFF87 0000000F
00000154 00000087 0000000F  00000158 FFFFA987 0000000F  0000015C 00005678 0000000F
00000160 87788778 0000000F

// File: testbench/tb_rv_core.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the RV32I core
// Memory models with random wait states and store checking
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam int pat_words    = 512;
    localparam int cnt_idx      = 'h100;    // Store count, records follow
    localparam int drain_cycles = 20;

    logic        clk;
    logic        resetb;
    imem_req_t   imem_req;
    imem_rsp_t   imem_rsp;
    dmem_wreq_t  dmem_wreq;
    logic        dmem_wvalid;
    dmem_rreq_t  dmem_rreq;
    dmem_rrsp_t  dmem_rrsp;
    logic        fetch_valid;
    logic        read_valid;
    logic [31:0] pat [0:pat_words-1];
    logic [31:0] dmem [0:255];
    logic [31:0] lcg_state;
    int          fetch_wait;
    int          read_wait;
    int          write_wait;
    int          n_exp;
    int          n_seen;
    int          n_pass;
    int          n_fail;
    int          prog_words;
    int          cycles;
    int          limit;

    rv_core i_rv_core (
        .clk         (clk),
        .resetb      (resetb),
        .imem_req    (imem_req),
        .imem_rsp    (imem_rsp),
        .dmem_wreq   (dmem_wreq),
        .dmem_wvalid (dmem_wvalid),
        .dmem_rreq   (dmem_rreq),
        .dmem_rrsp   (dmem_rrsp)
    );

    // Read data follows the address within the cycle
    assign imem_rsp  = {fetch_valid, pat[{1'b0, imem_req.addr[9:2]}]};
    assign dmem_rrsp = {read_valid, dmem[dmem_rreq.addr[9:2]]};

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick_wait(output int w);
        lcg_state = lcg_next(lcg_state);
        w = int'({30'b0, lcg_state[17:16]});    // 0 to 3 cycles
    endtask

    task automatic write_dmem;
        for (int b = 0; b < 4; b++) begin
            if (dmem_wreq.strb[b])
                dmem[dmem_wreq.addr[9:2]][8*b +: 8] = dmem_wreq.data[8*b +: 8];
        end
    endtask

    task automatic check_store;
        int          base;
        logic        bad;
        logic [31:0] e_addr;
        logic [31:0] e_data;
        logic [3:0]  e_strb;
        bad = 1'b0;
        if (n_seen >= n_exp) begin
            $display("Error: unexpected store %0d to address 0x%08h", n_seen, dmem_wreq.addr);
            n_fail++;
        end else begin
            base   = cnt_idx + 1 + 3 * n_seen;
            e_addr = pat[base];
            e_data = pat[base + 1];
            e_strb = pat[base + 2][3:0];
            if (dmem_wreq.addr != e_addr) begin
                $display("Error store_%0d: addr expected 0x%08h actual 0x%08h",
                         n_seen, e_addr, dmem_wreq.addr);
                bad = 1'b1;
            end
            if (dmem_wreq.data != e_data) begin
                $display("Error store_%0d: data expected 0x%08h actual 0x%08h",
                         n_seen, e_data, dmem_wreq.data);
                bad = 1'b1;
            end
            if (dmem_wreq.strb != e_strb) begin
                $display("Error store_%0d: strb expected 0x%01h actual 0x%01h",
                         n_seen, e_strb, dmem_wreq.strb);
                bad = 1'b1;
            end
            if (bad) begin
                $display("store_%0d failed", n_seen);
                n_fail++;
            end else begin
                $display("store_%0d ok", n_seen);
                n_pass++;
            end
        end
        n_seen++;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory response drive and transfer tracking
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #10;
        fetch_valid = (fetch_wait == 0);
        read_valid  = (read_wait == 0);
        dmem_wvalid = (write_wait == 0);
    end

    // Values at the falling edge are the ones seen at the next rising edge
    always @(negedge clk) begin
        if (resetb) begin
            cycles++;
            if (imem_req.ready) begin
                if (fetch_valid)
                    pick_wait(fetch_wait);
                else if (fetch_wait > 0)
                    fetch_wait--;
            end
            if (dmem_rreq.ready) begin
                if (read_valid)
                    pick_wait(read_wait);
                else if (read_wait > 0)
                    read_wait--;
            end
            if (dmem_wreq.ready) begin
                if (dmem_wvalid) begin
                    write_dmem();
                    check_store();
                    pick_wait(write_wait);
                end else if (write_wait > 0) begin
                    write_wait--;
                end
            end
            if (cycles > limit) begin
                $display("Timeout after %0d cycles: %0d of %0d stores never arrived",
                         cycles, n_exp - n_seen, n_exp);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

    initial begin
        resetb      = 1'b0;
        fetch_valid = 1'b0;
        read_valid  = 1'b0;
        dmem_wvalid = 1'b0;
        lcg_state   = 32'h7af27a0d;
        n_seen      = 0;
        n_pass      = 0;
        n_fail      = 0;
        cycles      = 0;
        for (int i = 0; i < pat_words; i++)
            pat[i] = '0;
        $readmemh("testbench/rv_patterns.hex", pat);
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0203);
        n_exp      = pat[cnt_idx];
        prog_words = 0;
        while (prog_words < cnt_idx && pat[prog_words] != '0)
            prog_words++;
        limit = 40 * prog_words + 200;
        if (n_exp == 0) begin
            $display("No expected stores found in the pattern file");
            n_fail++;
        end
        pick_wait(fetch_wait);
        pick_wait(read_wait);
        pick_wait(write_wait);

        repeat (3) @(posedge clk);
        #10 resetb = 1'b1;

        wait (n_seen >= n_exp);
        repeat (drain_cycles) @(posedge clk);    // Catch stray stores

        $display("Summary: %0d passed, %0d failed, %0d of %0d stores seen",
                 n_pass, n_fail, n_seen, n_exp);
        if (n_fail == 0 && n_seen == n_exp) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/rv_core.sv
//////////////////////////////////////////////////////////////////////
// Three-stage RV32I core
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       resetb,
    output imem_req_t  imem_req,
    input  imem_rsp_t  imem_rsp,
    output dmem_wreq_t dmem_wreq,
    input  logic       dmem_wvalid,
    output dmem_rreq_t dmem_rreq,
    input  dmem_rrsp_t dmem_rrsp
);

    dec_ex_t               dec;
    ex_wb_t                exw;
    dmem_wreq_t            store_req;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic                  redirect_taken;
    logic [xlen-1:0]       redirect_pc;
    logic                  exec_hold;
    logic                  wb_hold;
    logic                  hold;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_rd;
    logic [xlen-1:0]       wr_data;

    assign hold = exec_hold || wb_hold;    // Decode stalls on either

    rv_decode i_rv_decode (
        .clk            (clk),
        .resetb         (resetb),
        .imem_req       (imem_req),
        .imem_rsp       (imem_rsp),
        .hold           (hold),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc),
        .dec            (dec)
    );

    rv_regfile i_rv_regfile (
        .clk     (clk),
        .resetb  (resetb),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .wr_en   (wr_en),
        .wr_rd   (wr_rd),
        .wr_data (wr_data),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    rv_execute i_rv_execute (
        .clk            (clk),
        .resetb         (resetb),
        .dec            (dec),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .dmem_rreq      (dmem_rreq),
        .dmem_rrsp      (dmem_rrsp),
        .wb_hold        (wb_hold),
        .exec_hold      (exec_hold),
        .redirect_taken (redirect_taken),
        .redirect_pc    (redirect_pc),
        .exw            (exw),
        .store_req      (store_req)
    );

    rv_writeback i_rv_writeback (
        .clk             (clk),
        .resetb          (resetb),
        .exw             (exw),
        .store_req       (store_req),
        .dmem_wreq       (dmem_wreq),
        .dmem_wrsp_valid (dmem_wvalid),
        .wb_hold         (wb_hold),
        .wr_en           (wr_en),
        .wr_rd           (wr_rd),
        .wr_data         (wr_data)
    );

endmodule

// File: verilog/rv_decode.sv
//////////////////////////////////////////////////////////////////////
// Fetch and decode stage
// Fetch PC, branch squash, decode and the decode-to-execute register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            resetb,
    output imem_req_t       imem_req,
    input  imem_rsp_t       imem_rsp,
    input  logic            hold,
    input  logic            redirect_taken,
    input  logic [xlen-1:0] redirect_pc,
    output dec_ex_t         dec
);

    logic            started;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] tgt_pc;
    logic [1:0]      sq_cnt;        // Accepted slots still to squash
    logic            accept;
    logic            squash;
    logic [31:0]     insn;
    dec_ex_t         dec_nxt;

    assign imem_req.ready = started && !hold;    // Low for one cycle after reset
    assign imem_req.addr  = fetch_pc;
    assign accept         = imem_req.ready && imem_rsp.valid;
    assign squash         = redirect_taken || (sq_cnt != 2'd0);
    assign insn           = (accept && !squash) ? imem_rsp.rdata : nop_insn;

    always_comb begin
        dec_nxt             = '0;
        dec_nxt.pc          = fetch_pc;
        dec_nxt.rs1         = insn[19:15];
        dec_nxt.rs2         = insn[24:20];
        dec_nxt.rd          = insn[11:7];
        dec_nxt.ctrl.funct3 = insn[14:12];
        dec_nxt.valid       = accept && !squash;
        case (insn[6:0])
            op_lui, op_auipc: begin
                dec_nxt.ctrl.lui   = (insn[6:0] == op_lui);
                dec_nxt.ctrl.auipc = (insn[6:0] == op_auipc);
                dec_nxt.ctrl.wr_en = 1'b1;
                dec_nxt.imm        = {insn[31:12], 12'h000};
            end
            op_jal: begin
                dec_nxt.ctrl.jal   = 1'b1;
                dec_nxt.ctrl.wr_en = 1'b1;
                dec_nxt.imm        = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            op_jalr, op_load: begin
                dec_nxt.ctrl.jalr  = (insn[6:0] == op_jalr);
                dec_nxt.ctrl.load  = (insn[6:0] == op_load);
                dec_nxt.ctrl.wr_en = 1'b1;
                dec_nxt.imm        = {{20{insn[31]}}, insn[31:20]};
            end
            op_branch: begin
                dec_nxt.ctrl.branch = 1'b1;
                dec_nxt.imm         = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            op_store: begin
                dec_nxt.ctrl.store = 1'b1;
                dec_nxt.imm        = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            end
            op_arithi: begin
                dec_nxt.ctrl.alu     = 1'b1;
                dec_nxt.ctrl.imm_sel = 1'b1;
                dec_nxt.ctrl.sub_sra = insn[30] && (insn[14:12] == f3_sr); // SRAI only
                dec_nxt.ctrl.wr_en   = 1'b1;
                dec_nxt.imm          = {{20{insn[31]}}, insn[31:20]};
            end
            op_arithr: begin
                dec_nxt.ctrl.alu     = 1'b1;
                dec_nxt.ctrl.sub_sra = insn[30];
                dec_nxt.ctrl.wr_en   = 1'b1;
            end
            default: ;    // Unknown opcode runs as a no-op
        endcase
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            started  <= 1'b0;
            fetch_pc <= reset_vec;
            sq_cnt   <= 2'd0;
            dec      <= '0;
        end else begin
            started <= 1'b1;
            if (!hold)
                dec <= dec_nxt;
            if (redirect_taken) begin
                sq_cnt <= accept ? 2'd1 : 2'd2;
                if (accept)
                    fetch_pc <= fetch_pc + 32'd4;
            end else if (accept) begin
                fetch_pc <= (sq_cnt == 2'd1) ? tgt_pc : fetch_pc + 32'd4;
                if (sq_cnt != 2'd0)
                    sq_cnt <= sq_cnt - 2'd1;
            end
        end
    end

    // Target waits here until the fetch after the second squashed slot
    always_ff @(posedge clk) begin
        if (redirect_taken)
            tgt_pc <= redirect_pc;
    end

endmodule

// File: verilog/rv_execute.sv
//////////////////////////////////////////////////////////////////////
// Execute stage
// ALU, branches and jumps, load issue, store formatting
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            resetb,
    input  dec_ex_t         dec,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    output dmem_rreq_t      dmem_rreq,
    input  dmem_rrsp_t      dmem_rrsp,
    input  logic            wb_hold,
    output logic            exec_hold,
    output logic            redirect_taken,
    output logic [xlen-1:0] redirect_pc,
    output ex_wb_t          exw,
    output dmem_wreq_t      store_req
);

    ctrl_t           c;
    logic [xlen-1:0] op2;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] result;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] pc_imm;
    logic            cond;
    logic            ld_wait;

    assign c        = dec.ctrl;
    assign op2      = c.imm_sel ? dec.imm : rdata2;
    assign shamt    = op2[4:0];
    assign mem_addr = rdata1 + dec.imm;    // Also the JALR target
    assign pc_imm   = dec.pc + dec.imm;

    //////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (c.funct3)
            f3_add:  alu_res = c.sub_sra ? rdata1 - op2 : rdata1 + op2;
            f3_sll:  alu_res = rdata1 << shamt;
            f3_slt:  alu_res = {31'h0, $signed(rdata1) < $signed(op2)};
            f3_sltu: alu_res = {31'h0, rdata1 < op2};
            f3_xor:  alu_res = rdata1 ^ op2;
            f3_sr:   alu_res = c.sub_sra ? $unsigned($signed(rdata1) >>> shamt) : rdata1 >> shamt;
            f3_or:   alu_res = rdata1 | op2;
            default: alu_res = rdata1 & op2;
        endcase
    end

    always_comb begin
        case (c.funct3)
            f3_beq:  cond = (rdata1 == rdata2);
            f3_bne:  cond = (rdata1 != rdata2);
            f3_blt:  cond = $signed(rdata1) < $signed(rdata2);
            f3_bge:  cond = $signed(rdata1) >= $signed(rdata2);
            f3_bltu: cond = rdata1 < rdata2;
            f3_bgeu: cond = rdata1 >= rdata2;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (c.lui)
            result = dec.imm;
        else if (c.auipc)
            result = pc_imm;
        else if (c.jal || c.jalr)
            result = dec.pc + 32'd4;    // Link
        else if (c.load)
            result = dmem_rrsp.data;
        else if (c.alu)
            result = alu_res;
        else
            result = '0;
    end

    // Redirect only when the instruction leaves execute
    assign redirect_taken = dec.valid && !wb_hold && (c.jal || c.jalr || (c.branch && cond));
    assign redirect_pc    = c.jalr ? {mem_addr[xlen-1:1], 1'b0} : pc_imm;

    //////////////////////////////////////////////////////////////////////
    // Memory requests
    //////////////////////////////////////////////////////////////////////
    assign dmem_rreq.ready = dec.valid && c.load && !wb_hold;
    assign dmem_rreq.addr  = mem_addr;
    assign ld_wait         = dec.valid && c.load && !dmem_rrsp.valid;
    assign exec_hold       = ld_wait;

    always_comb begin
        store_req.ready = dec.valid && c.store;
        store_req.addr  = mem_addr;
        case (c.funct3)
            f3_lb: begin
                store_req.data = {4{rdata2[7:0]}};
                store_req.strb = 4'b0001 << mem_addr[1:0];
            end
            f3_lh: begin
                store_req.data = {2{rdata2[15:0]}};
                store_req.strb = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_req.data = rdata2;
                store_req.strb = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            exw <= '0;
        end else if (!wb_hold) begin
            exw.valid   <= dec.valid && !ld_wait;    // Bubble while a load waits
            exw.result  <= result;
            exw.rd      <= dec.rd;
            exw.wr_en   <= c.wr_en;
            exw.load    <= c.load;
            exw.funct3  <= c.funct3;
            exw.addr_lo <= mem_addr[1:0];
        end
    end

endmodule

// File: verilog/rv_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I core package
// Opcodes, function codes, widths and the pipeline stage structs
//////////////////////////////////////////////////////////////////////
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_vec = 32'h0000_0000;
    localparam logic [31:0]     nop_insn  = 32'h0000_0013;    // ADDI x0,x0,0

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_arithi = 7'b0010011;
    localparam logic [6:0] op_arithr = 7'b0110011;

    // ALU funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Load and store sizes
    localparam logic [2:0] f3_lb   = 3'b000;
    localparam logic [2:0] f3_lh   = 3'b001;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_lbu  = 3'b100;
    localparam logic [2:0] f3_lhu  = 3'b101;

    typedef struct packed {
        logic       alu;
        logic       sub_sra;
        logic       imm_sel;
        logic       lui;
        logic       auipc;
        logic       jal;
        logic       jalr;
        logic       branch;
        logic       load;
        logic       store;
        logic       wr_en;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        ctrl_t                 ctrl;
        logic                  valid;
    } dec_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       result;    // Raw read word for loads
        logic [reg_addr_w-1:0] rd;
        logic                  wr_en;
        logic                  load;
        logic [2:0]            funct3;
        logic [1:0]            addr_lo;
        logic                  valid;
    } ex_wb_t;

    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     rdata;
    } imem_rsp_t;

    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic [3:0]      strb;
    } dmem_wreq_t;

    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] addr;
    } dmem_rreq_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } dmem_rrsp_t;

endpackage

// File: verilog/rv_regfile.sv
//////////////////////////////////////////////////////////////////////
// Integer register file
// x1 to x31 with forwarding from write back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  resetb,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_rd,
    input  logic [xlen-1:0]       wr_data,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [1:31];
    logic            fwd1;
    logic            fwd2;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_rd != '0)) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // Bypass the write in flight
    assign fwd1 = wr_en && (wr_rd == rs1);
    assign fwd2 = wr_en && (wr_rd == rs2);

    assign rdata1 = (rs1 == '0) ? '0 :    // x0 always reads zero
                    fwd1        ? wr_data : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 :
                    fwd2        ? wr_data : regs[rs2];

endmodule

// File: verilog/rv_writeback.sv
//////////////////////////////////////////////////////////////////////
// Write back stage
// Load lane extraction, register write and store request holding
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_writeback import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  resetb,
    input  ex_wb_t                exw,
    input  dmem_wreq_t            store_req,
    output dmem_wreq_t            dmem_wreq,
    input  logic                  dmem_wrsp_valid,
    output logic                  wb_hold,
    output logic                  wr_en,
    output logic [reg_addr_w-1:0] wr_rd,
    output logic [xlen-1:0]       wr_data
);

    dmem_wreq_t      wreq_q;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] load_data;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb)
            wreq_q <= '0;
        else if (!wb_hold)
            wreq_q <= store_req;
    end

    assign dmem_wreq = wreq_q;
    assign wb_hold   = wreq_q.ready && !dmem_wrsp_valid;    // Store not yet taken

    // Move the addressed lane down to bit 0
    assign lane = exw.result >> {exw.addr_lo, 3'b000};

    always_comb begin
        case (exw.funct3)
            f3_lb:   load_data = {{24{lane[7]}}, lane[7:0]};
            f3_lbu:  load_data = {24'h0, lane[7:0]};
            f3_lh:   load_data = {{16{lane[15]}}, lane[15:0]};
            f3_lhu:  load_data = {16'h0, lane[15:0]};
            f3_lw:   load_data = exw.result;
            default: load_data = exw.result;
        endcase
    end

    assign wr_en   = exw.valid && exw.wr_en;
    assign wr_rd   = exw.rd;
    assign wr_data = exw.load ? load_data : exw.result;

endmodule

// File: vlog.f
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_regfile.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv
